// File: include/mc_config.svh
// row size, field widths and FIFO depths for the memory tile row

`ifndef MC_CONFIG_SVH
`define MC_CONFIG_SVH

// tiles in the row, one x coordinate each
// the row sits at y = 0, no y routing in this network
`define MC_NUM_TILES   4
`define MC_X_WIDTH     2

// word address inside one tile, 16 words
`define MC_ADDR_WIDTH  4
`define MC_DATA_WIDTH  32

// endpoint request buffer depth
`define MC_FWD_ELS     4
// host return buffer depth
`define MC_RET_ELS     2

`endif

// File: verilog/mc_pkg.sv
// operation enum and request, request body and return packet structs

`include "mc_config.svh"

package mc_pkg;

  // ------------------------------------------------------------------
  // operation
  // ------------------------------------------------------------------
  typedef enum logic {
    MC_OP_LOAD  = 1'b0,
    MC_OP_STORE = 1'b1
  } mc_op_e;

  // ------------------------------------------------------------------
  // request packets
  // ------------------------------------------------------------------
  // body only, destination already stripped by the endpoint
  typedef struct packed {
    mc_op_e                     op;
    logic [`MC_ADDR_WIDTH-1:0]  addr;
    logic [`MC_DATA_WIDTH-1:0]  data;
  } mc_req_body_s;

  // full request as seen on the network
  // dst_x in the low bits, same as the mesh packet layout
  typedef struct packed {
    mc_req_body_s               body;
    logic [`MC_X_WIDTH-1:0]     dst_x;
  } mc_packet_s;

  // ------------------------------------------------------------------
  // return packet
  // ------------------------------------------------------------------
  // load: data read, store: data written
  typedef struct packed {
    mc_op_e                     op;
    logic [`MC_X_WIDTH-1:0]     x;
    logic [`MC_ADDR_WIDTH-1:0]  addr;
    logic [`MC_DATA_WIDTH-1:0]  data;
  } mc_return_packet_s;

endpackage

// File: verilog/mc_fifo_small.sv
// small circular FIFO with typed payload, valid/ready in and valid/yumi out

module mc_fifo_small
  import mc_pkg::*;
  #(parameter type payload_t = mc_req_body_s
    , parameter int els_p = 4
  )
  (
    input               clk_i
    , input             arst_n_i

    // enqueue side, valid/ready
    , input             v_i
    , input  payload_t  data_i
    , output logic      ready_o

    // dequeue side, valid/yumi
    , output logic      v_o
    , output payload_t  data_o
    , input             yumi_i
  );

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  // storage
  payload_t mem_r [els_p];

  logic [ptr_w_lp-1:0] wptr_r, rptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                enq, deq;

  // full blocks enqueue even with a dequeue in the same cycle
  assign ready_o = (count_r != cnt_w_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ready_o;
  // yumi only while v_o, so empty never dequeues
  assign deq = yumi_i;

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        // wrap explicitly, depth need not be a power of two
        wptr_r <= (wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (deq) begin
        rptr_r <= (rptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      // net change in occupancy
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // payload write, new entry visible after the edge
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

// File: verilog/mc_endpoint.sv
// per-tile network endpoint: request buffer, destination strip, return stamping

`include "mc_config.svh"

module mc_endpoint
  import mc_pkg::*;
  #(parameter logic [`MC_X_WIDTH-1:0] x_cord_p = '0
  )
  (
    input                       clk_i
    , input                     arst_n_i

    // request link from the router
    , input                     link_fwd_v_i
    , input  mc_packet_s        link_fwd_data_i
    , output logic              link_fwd_ready_o

    // request toward the tile memory
    , output mc_req_body_s      packet_o
    , output logic              packet_v_o
    , input                     packet_yumi_i

    // return from the tile memory
    , input  mc_return_packet_s return_packet_i
    , input                     return_packet_v_i
    , output logic              return_packet_ready_o

    // return link toward the arbiter
    , output logic              link_rev_v_o
    , output mc_return_packet_s link_rev_data_o
    , input                     link_rev_ready_i
  );

  // ------------------------------------------------------------------
  // incoming requests
  // ------------------------------------------------------------------
  // memory may be busy with a return, so requests queue here
  // only the body is stored, dst_x already matched this tile
  mc_fifo_small #(
    .payload_t (mc_req_body_s)
    , .els_p   (`MC_FWD_ELS)
  ) u_fwd_fifo (
    .clk_i     (clk_i)
    , .arst_n_i(arst_n_i)

    , .v_i     (link_fwd_v_i)
    , .data_i  (link_fwd_data_i.body)
    , .ready_o (link_fwd_ready_o)

    , .v_o     (packet_v_o)
    , .data_o  (packet_o)
    , .yumi_i  (packet_yumi_i)
  );

  // ------------------------------------------------------------------
  // outgoing returns
  // ------------------------------------------------------------------
  // valid and ready go straight through
  assign link_rev_v_o          = return_packet_v_i;
  assign return_packet_ready_o = link_rev_ready_i;

  // responder x comes from this endpoint, memory leaves it blank
  always_comb begin
    link_rev_data_o   = return_packet_i;
    link_rev_data_o.x = x_cord_p;
  end

endmodule

// File: verilog/mc_tile_mem.sv
// per-tile word memory serving one load or store per request

`include "mc_config.svh"

module mc_tile_mem
  import mc_pkg::*;
  (
    input                       clk_i
    , input                     arst_n_i

    // request from the endpoint
    , input  mc_req_body_s      packet_i
    , input                     packet_v_i
    , output logic              packet_yumi_o

    // return toward the endpoint
    , output mc_return_packet_s return_packet_o
    , output logic              return_packet_v_o
    , input                     return_packet_ready_i
  );

  localparam int words_lp = 1 << `MC_ADDR_WIDTH;

  // word array, starts from zero after reset
  logic [`MC_DATA_WIDTH-1:0] mem_r [words_lp];

  // one-entry return register
  mc_return_packet_s ret_r;
  logic              ret_v_r;

  // take a request only with the return slot free
  assign packet_yumi_o     = packet_v_i & ~ret_v_r;
  assign return_packet_o   = ret_r;
  assign return_packet_v_o = ret_v_r;

  // ------------------------------------------------------------------
  // array and return valid
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ret_v_r <= 1'b0;
      for (int k = 0; k < words_lp; k++) begin
        mem_r[k] <= '0;
      end
    end else begin
      if (packet_yumi_o) begin
        ret_v_r <= 1'b1;
        if (packet_i.op == MC_OP_STORE) begin
          mem_r[packet_i.addr] <= packet_i.data;
        end
      end else if (return_packet_ready_i) begin
        // return handed to the network
        ret_v_r <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // return payload
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (packet_yumi_o) begin
      ret_r.op   <= packet_i.op;
      // x is stamped by the endpoint
      ret_r.x    <= '0;
      ret_r.addr <= packet_i.addr;
      // store echoes its data, load returns the old word
      ret_r.data <= (packet_i.op == MC_OP_STORE) ? packet_i.data : mem_r[packet_i.addr];
    end
  end

endmodule

// File: verilog/mc_fwd_router.sv
// request router decoding destination x onto one endpoint

`include "mc_config.svh"

module mc_fwd_router
  import mc_pkg::*;
  (
    // host request, valid/ready
    input                               req_v_i
    , input  mc_packet_s                req_data_i
    , output logic                      req_ready_o

    // one request link per tile, data shared
    , output logic [`MC_NUM_TILES-1:0]  fwd_v_o
    , output mc_packet_s                fwd_data_o
    , input        [`MC_NUM_TILES-1:0]  fwd_ready_i
  );

  // ------------------------------------------------------------------
  // destination decode
  // ------------------------------------------------------------------
  // purely combinational, no storage in the router
  // valid depends only on req_v_i and dst_x, never on ready

  // every endpoint sees the same packet
  assign fwd_data_o = req_data_i;

  always_comb begin
    fwd_v_o     = '0;
    req_ready_o = 1'b0;
    for (int i = 0; i < `MC_NUM_TILES; i++) begin
      if (req_data_i.dst_x == `MC_X_WIDTH'(i)) begin
        // steer to the matching tile
        fwd_v_o[i]  = req_v_i;
        // host sees the ready of the selected tile only
        req_ready_o = fwd_ready_i[i];
      end
    end
  end

endmodule

// File: verilog/mc_rev_arbiter.sv
// round-robin collection of tile returns into the host return FIFO

`include "mc_config.svh"

module mc_rev_arbiter
  import mc_pkg::*;
  (
    input                                      clk_i
    , input                                    arst_n_i

    // return links from the tiles
    , input        [`MC_NUM_TILES-1:0]         rev_v_i
    , input  mc_return_packet_s [`MC_NUM_TILES-1:0] rev_data_i
    , output logic [`MC_NUM_TILES-1:0]         rev_ready_o

    // host return, valid/yumi
    , output logic                             ret_v_o
    , output mc_return_packet_s                ret_data_o
    , input                                    ret_yumi_i
  );

  localparam int n_lp     = `MC_NUM_TILES;
  localparam int idx_w_lp = (n_lp > 1) ? $clog2(n_lp) : 1;

  logic [idx_w_lp-1:0] last_r, gnt_idx, cand_idx;
  logic                gnt_v;
  logic                fifo_ready;

  // ------------------------------------------------------------------
  // round-robin pick
  // ------------------------------------------------------------------
  // search starts at the tile after the last grant
  always_comb begin
    gnt_v    = 1'b0;
    gnt_idx  = last_r;
    cand_idx = last_r;
    for (int off = 1; off <= n_lp; off++) begin
      cand_idx = idx_w_lp'((int'(last_r) + off) % n_lp);
      if (!gnt_v && rev_v_i[cand_idx]) begin
        gnt_v   = 1'b1;
        gnt_idx = cand_idx;
      end
    end
  end

  // grant only while the FIFO can take the winner
  always_comb begin
    rev_ready_o = '0;
    if (gnt_v && fifo_ready) begin
      rev_ready_o[gnt_idx] = 1'b1;
    end
  end

  // pointer moves on a real transfer only
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // first search starts at tile 0
      last_r <= idx_w_lp'(n_lp - 1);
    end else if (gnt_v && fifo_ready) begin
      last_r <= gnt_idx;
    end
  end

  // ------------------------------------------------------------------
  // host return buffer
  // ------------------------------------------------------------------
  mc_fifo_small #(
    .payload_t (mc_return_packet_s)
    , .els_p   (`MC_RET_ELS)
  ) u_ret_fifo (
    .clk_i     (clk_i)
    , .arst_n_i(arst_n_i)
    , .v_i     (gnt_v)
    , .data_i  (rev_data_i[gnt_idx])
    , .ready_o (fifo_ready)
    , .v_o     (ret_v_o)
    , .data_o  (ret_data_o)
    , .yumi_i  (ret_yumi_i)
  );

endmodule

// File: verilog/mc_row_top.sv
// row top: router, generated endpoint and memory pairs, return arbiter

`include "mc_config.svh"

module mc_row_top
  import mc_pkg::*;
  (
    input                       clk_i
    , input                     arst_n_i

    // host request, valid/ready
    , input                     req_v_i
    , input  mc_packet_s        req_data_i
    , output logic              req_ready_o

    // host return, valid/yumi
    , output logic              ret_v_o
    , output mc_return_packet_s ret_data_o
    , input                     ret_yumi_i
  );

  // router to endpoints
  logic [`MC_NUM_TILES-1:0] fwd_v, fwd_ready;
  mc_packet_s               fwd_data;

  // endpoint and memory, per tile
  mc_req_body_s      [`MC_NUM_TILES-1:0] mem_pkt;
  logic              [`MC_NUM_TILES-1:0] mem_pkt_v, mem_pkt_yumi;
  mc_return_packet_s [`MC_NUM_TILES-1:0] mem_ret;
  logic              [`MC_NUM_TILES-1:0] mem_ret_v, mem_ret_ready;

  // endpoints to arbiter
  logic              [`MC_NUM_TILES-1:0] rev_v, rev_ready;
  mc_return_packet_s [`MC_NUM_TILES-1:0] rev_data;

  // ------------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------------
  mc_fwd_router u_router (
    .req_v_i      (req_v_i)
    , .req_data_i (req_data_i)
    , .req_ready_o(req_ready_o)
    , .fwd_v_o    (fwd_v)
    , .fwd_data_o (fwd_data)
    , .fwd_ready_i(fwd_ready)
  );

  // ------------------------------------------------------------------
  // tile pairs, x taken from the loop index
  // ------------------------------------------------------------------
  for (genvar i = 0; i < `MC_NUM_TILES; i++) begin : g_tile
    mc_endpoint #(
      .x_cord_p (`MC_X_WIDTH'(i))
    ) u_ep (
      .clk_i                  (clk_i)
      , .arst_n_i             (arst_n_i)
      , .link_fwd_v_i         (fwd_v[i])
      , .link_fwd_data_i      (fwd_data)
      , .link_fwd_ready_o     (fwd_ready[i])
      , .packet_o             (mem_pkt[i])
      , .packet_v_o           (mem_pkt_v[i])
      , .packet_yumi_i        (mem_pkt_yumi[i])
      , .return_packet_i      (mem_ret[i])
      , .return_packet_v_i    (mem_ret_v[i])
      , .return_packet_ready_o(mem_ret_ready[i])
      , .link_rev_v_o         (rev_v[i])
      , .link_rev_data_o      (rev_data[i])
      , .link_rev_ready_i     (rev_ready[i])
    );

    mc_tile_mem u_mem (
      .clk_i                  (clk_i)
      , .arst_n_i             (arst_n_i)
      , .packet_i             (mem_pkt[i])
      , .packet_v_i           (mem_pkt_v[i])
      , .packet_yumi_o        (mem_pkt_yumi[i])
      , .return_packet_o      (mem_ret[i])
      , .return_packet_v_o    (mem_ret_v[i])
      , .return_packet_ready_i(mem_ret_ready[i])
    );
  end

  // ------------------------------------------------------------------
  // return collection
  // ------------------------------------------------------------------
  mc_rev_arbiter u_arb (
    .clk_i        (clk_i)
    , .arst_n_i   (arst_n_i)
    , .rev_v_i    (rev_v)
    , .rev_data_i (rev_data)
    , .rev_ready_o(rev_ready)
    , .ret_v_o    (ret_v_o)
    , .ret_data_o (ret_data_o)
    , .ret_yumi_i (ret_yumi_i)
  );

endmodule

// File: dv/mc_properties.sv
// concurrent checks on the row top host request and return handshakes

module mc_properties
  import mc_pkg::*;
  (
    input                      clk_i
    , input                    arst_n_i
    , input                    req_v_i
    , input mc_packet_s        req_data_i
    , input                    req_ready_o
    , input                    ret_v_o
    , input mc_return_packet_s ret_data_o
    , input                    ret_yumi_i
  );

  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------------------------------------
  // host return side, valid/yumi
  // ----------------------------------------------------------------------
  // waiting return stays valid and unchanged until taken
  a_ret_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ret_v_o && !ret_yumi_i |=> ret_v_o && $stable(ret_data_o)
  ) else $error("return packet changed before yumi");

  // yumi only on a valid return
  a_yumi_with_v: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ret_yumi_i |-> ret_v_o
  ) else $error("yumi raised without a valid return");

  // ----------------------------------------------------------------------
  // host request side, valid/ready
  // ----------------------------------------------------------------------
  // same destination, no transfer last cycle, so its ready cannot drop
  a_req_ready_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_v_i && $stable(req_data_i.dst_x) && !$past(req_v_i && req_ready_o)
      |-> !$fell(req_ready_o)
  ) else $error("request ready dropped without a transfer");

endmodule

// attach to every row top
bind mc_row_top mc_properties u_props (.*);

// File: dv/mc_tb.sv
// testbench for the memory tile row: stimulus, reference model, return checks

`include "mc_config.svh"

module mc_tb
  import mc_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          words_lp      = 1 << `MC_ADDR_WIDTH;
  localparam int          wait_limit_lp = 200;
  localparam int          drain_limit_lp = 4000;
  localparam logic [31:0] seed_lp       = 32'h6671_0a27;
  // host yumi behaviour
  localparam logic [1:0]  yumi_always_lp = 2'd0;
  localparam logic [1:0]  yumi_hold_lp   = 2'd1;
  localparam logic [1:0]  yumi_rand_lp   = 2'd2;

  logic              clk_i;
  logic              arst_n_i;
  logic              req_v_i;
  mc_packet_s        req_data_i;
  logic              req_ready_o;
  logic              ret_v_o;
  mc_return_packet_s ret_data_o;
  logic              ret_yumi_i = 1'b0;

  // reference model state, one memory and one queue per tile
  logic [`MC_DATA_WIDTH-1:0] model_mem [`MC_NUM_TILES][words_lp];
  mc_return_packet_s         exp_q [`MC_NUM_TILES][$];
  mc_return_packet_s         exp_pkt;
  logic [31:0]               stim_state;
  logic [31:0]               yumi_state = seed_lp;
  logic [1:0]                yumi_mode = yumi_always_lp;
  int                        req_count;
  int                        ret_count;

  mc_row_top u_dut (
    .clk_i        (clk_i)
    , .arst_n_i   (arst_n_i)
    , .req_v_i    (req_v_i)
    , .req_data_i (req_data_i)
    , .req_ready_o(req_ready_o)
    , .ret_v_o    (ret_v_o)
    , .ret_data_o (ret_data_o)
    , .ret_yumi_i (ret_yumi_i)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string what, input logic [`MC_DATA_WIDTH-1:0] got,
                             input logic [`MC_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL time %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic mc_packet_s make_packet(input int x, input mc_op_e op, input int addr,
                                             input logic [`MC_DATA_WIDTH-1:0] data);
    mc_packet_s pkt;
    pkt.dst_x     = `MC_X_WIDTH'(x);
    pkt.body.op   = op;
    pkt.body.addr = `MC_ADDR_WIDTH'(addr);
    pkt.body.data = data;
    return pkt;
  endfunction

  // negative tile picks a random one
  function automatic mc_packet_s random_packet(input int tile);
    mc_packet_s  pkt;
    logic [31:0] r;
    r             = next_stim();
    pkt.dst_x     = (tile < 0) ? r[`MC_X_WIDTH-1:0] : `MC_X_WIDTH'(tile);
    pkt.body.op   = r[8] ? MC_OP_STORE : MC_OP_LOAD;
    pkt.body.addr = r[12 +: `MC_ADDR_WIDTH];
    pkt.body.data = next_stim();
    return pkt;
  endfunction

  // expected reply, model updated in acceptance order
  function automatic mc_return_packet_s predict_return(input mc_packet_s pkt);
    mc_return_packet_s exp;
    exp.op   = pkt.body.op;
    exp.x    = pkt.dst_x;
    exp.addr = pkt.body.addr;
    if (pkt.body.op == MC_OP_STORE) begin
      exp.data = pkt.body.data;
      model_mem[pkt.dst_x][pkt.body.addr] = pkt.body.data;
    end else begin
      exp.data = model_mem[pkt.dst_x][pkt.body.addr];
    end
    return exp;
  endfunction

  task automatic record_accept(input mc_packet_s pkt);
    exp_q[pkt.dst_x].push_back(predict_return(pkt));
    req_count++;
  endtask

  // ----------------------------------------------------------------------
  // request driving, entered and left on a falling edge
  // ----------------------------------------------------------------------
  task automatic wait_accept(input mc_packet_s pkt);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      if (req_ready_o) begin
        record_accept(pkt);
        accepted = 1'b1;
      end else if (waited == wait_limit_lp) begin
        $display("timeout: request to tile %0d was never accepted", pkt.dst_x);
        abort_run();
      end
      waited++;
      @(negedge clk_i);
    end
    req_v_i = 1'b0;
  endtask

  task automatic send_request(input mc_packet_s pkt);
    req_data_i = pkt;
    req_v_i    = 1'b1;
    wait_accept(pkt);
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (ret_count != req_count) begin
      if (waited == drain_limit_lp) begin
        $display("timeout: only %0d of %0d returns arrived", ret_count, req_count);
        abort_run();
      end
      waited++;
      @(negedge clk_i);
    end
  endtask

  // ----------------------------------------------------------------------
  // host return side
  // ----------------------------------------------------------------------
  // yumi only where the return is already valid
  always @(negedge clk_i) begin
    yumi_state = xorshift32(yumi_state);
    case (yumi_mode)
      yumi_hold_lp: ret_yumi_i = 1'b0;
      yumi_rand_lp: ret_yumi_i = ret_v_o & (yumi_state[5:4] != 2'b00);
      default:      ret_yumi_i = ret_v_o;
    endcase
  end

  // compare each taken return with the head of its tile queue
  always @(posedge clk_i) begin
    if (arst_n_i && ret_v_o && ret_yumi_i) begin
      if (exp_q[ret_data_o.x].size() == 0) begin
        $display("return from tile %0d with no request outstanding", ret_data_o.x);
        abort_run();
      end else begin
        exp_pkt = exp_q[ret_data_o.x].pop_front();
        check_value("return op", `MC_DATA_WIDTH'(ret_data_o.op), `MC_DATA_WIDTH'(exp_pkt.op));
        check_value("return x", `MC_DATA_WIDTH'(ret_data_o.x), `MC_DATA_WIDTH'(exp_pkt.x));
        check_value("return addr", `MC_DATA_WIDTH'(ret_data_o.addr),
                    `MC_DATA_WIDTH'(exp_pkt.addr));
        check_value("return data", ret_data_o.data, exp_pkt.data);
        ret_count++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    mc_packet_s pkt;
    logic       stalled;
    int         sent;
    int         pending;
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    req_v_i    = 1'b0;
    req_data_i = '0;
    stim_state = seed_lp;
    req_count  = 0;
    ret_count  = 0;
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      for (int a = 0; a < words_lp; a++) begin
        model_mem[t][a] = '0;
      end
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // every word of every tile reads zero after reset
    // tiles drained one by one so a wrong responder x hits an empty queue
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      for (int a = 0; a < words_lp; a++) begin
        send_request(make_packet(t, MC_OP_LOAD, a, '0));
      end
      wait_for_drain();
    end

    // two stores per tile to one address, last one wins on readback
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      send_request(make_packet(t, MC_OP_STORE, 5, next_stim()));
      send_request(make_packet(t, MC_OP_STORE, 5, next_stim()));
    end
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      send_request(make_packet(t, MC_OP_LOAD, 5, '0));
    end
    wait_for_drain();

    // mixed traffic, host always takes
    repeat (200) send_request(random_packet(-1));
    wait_for_drain();

    // host stops taking, fill until the request side stalls
    yumi_mode = yumi_hold_lp;
    stalled   = 1'b0;
    sent      = 0;
    while (!stalled && sent < 64) begin
      pkt        = random_packet(-1);
      req_data_i = pkt;
      req_v_i    = 1'b1;
      @(posedge clk_i);
      if (req_ready_o) begin
        record_accept(pkt);
      end else begin
        stalled = 1'b1;
      end
      sent++;
      @(negedge clk_i);
    end
    check_value("request stall under held yumi", `MC_DATA_WIDTH'(stalled), `MC_DATA_WIDTH'(1));
    // blocked request stays pending while returns are held
    repeat (20) begin
      @(posedge clk_i);
      check_value("req_ready_o while blocked", `MC_DATA_WIDTH'(req_ready_o), '0);
      @(negedge clk_i);
    end
    yumi_mode = yumi_always_lp;
    wait_accept(pkt);
    wait_for_drain();

    // random yumi gaps, one tile then all tiles
    yumi_mode = yumi_rand_lp;
    repeat (40) send_request(random_packet(2));
    repeat (80) send_request(random_packet(-1));
    wait_for_drain();

    pending = 0;
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      pending += exp_q[t].size();
    end
    if (pending == 0 && ret_count == req_count) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("%0d expected returns never arrived", pending);
      abort_run();
    end
  end

endmodule

// File: build.f
+incdir+include
verilog/mc_pkg.sv
verilog/mc_fifo_small.sv
verilog/mc_endpoint.sv
verilog/mc_tile_mem.sv
verilog/mc_fwd_router.sv
verilog/mc_rev_arbiter.sv
verilog/mc_row_top.sv
dv/mc_properties.sv
dv/mc_tb.sv

// File: Makefile
# Verilator build and run for the memory tile row testbench

TOP := mc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f build.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
